/* filelist.f */
src/mem_pkg.sv
src/mem_agu.sv
src/mem_scratchpad.sv
src/mem_late_wb.sv
src/mem_pipe_top.sv
tb/tb_mem_checker.sv
tb/tb_mem_pipe.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_mem_pipe -f filelist.f -o tb_mem_pipe
	./obj_dir/tb_mem_pipe | tee sim.log
	grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_mem_pipe.sv */
`timescale 1ns/100ps

module tb_mem_pipe;

  logic              clk;
  logic              arst_n;
  logic              req_v;
  mem_pkg::mem_req_s req;
  logic              busy;
  logic [3:0]        flags;
  logic              iwb_v;
  logic              fwb_v;
  logic              iwb_yumi;
  logic              fwb_yumi;
  mem_pkg::wb_pkt_s  wb;
  int                err_cnt;
  int                chk_cnt;
  int                pending;
  int                timeouts;
  logic [31:0]       stim_state;
  logic [31:0]       yumi_state;
  int                yumi_delay;

  mem_pipe_top
   i_mem_pipe_top
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.req_v_i(req_v)
     ,.req_i(req)
     ,.busy_o(busy)
     ,.load_misaligned_o(flags[3])
     ,.store_misaligned_o(flags[2])
     ,.load_access_fault_o(flags[1])
     ,.store_access_fault_o(flags[0])
     ,.iwb_v_o(iwb_v)
     ,.fwb_v_o(fwb_v)
     ,.wb_o(wb)
     ,.iwb_yumi_i(iwb_yumi)
     ,.fwb_yumi_i(fwb_yumi)
     );

  tb_mem_checker
   i_checker
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.req_v_i(req_v)
     ,.req_i(req)
     ,.busy_i(busy)
     ,.flags_i(flags)
     ,.iwb_v_i(iwb_v)
     ,.fwb_v_i(fwb_v)
     ,.iwb_yumi_i(iwb_yumi)
     ,.fwb_yumi_i(fwb_yumi)
     ,.wb_i(wb)
     ,.err_cnt_o(err_cnt)
     ,.chk_cnt_o(chk_cnt)
     ,.pending_o(pending)
     );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic int op_bytes(mem_pkg::mem_op_e op);
    case (op)
      mem_pkg::e_lb, mem_pkg::e_lbu, mem_pkg::e_sb: return 1;
      mem_pkg::e_lh, mem_pkg::e_lhu, mem_pkg::e_sh: return 2;
      mem_pkg::e_ld, mem_pkg::e_sd, mem_pkg::e_fld, mem_pkg::e_fsd: return 8;
      default: return 4;
    endcase
  endfunction

  // Mostly aligned scratchpad addresses, some misaligned or out of range
  task automatic random_request(output mem_pkg::mem_req_s r);
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    mem_pkg::dword_t addr;
    mem_pkg::dword_t imm;
    a = draw();
    b = draw();
    c = draw();
    r.op      = mem_pkg::mem_op_e'(4'(a % 32'd15));
    r.rd_addr = a[12:8];
    r.rs2     = {b ^ a, c};
    imm       = {{52{c[11]}}, c[11:0]};
    case (a[19:16])
      4'd0:    addr = 64'(b % 32'd1024);
      4'd1:    addr = 64'(mem_pkg::MEM_BYTES) + 64'(b % 32'd4096);
      4'd2:    addr = ({b, c} | 64'h8000_0000_0000_0000) & ~64'd7;
      default: addr = 64'(b % 32'd1024) & ~(64'(op_bytes(r.op)) - 64'd1);
    endcase
    r.imm = imm;
    r.rs1 = addr - imm;
  endtask

  // Called on a falling edge and leaves req_v high for back-to-back requests
  task automatic send(input mem_pkg::mem_req_s r);
    int waited;
    waited = 0;
    while (busy && waited < 40)
      begin
        req_v = 1'b0;
        @(negedge clk);
        waited++;
      end
    if (busy)
      begin
        $display("Timeout at %0t: busy_o stayed high for %0d cycles", $time, waited);
        timeouts++;
        req_v = 1'b0;
      end
    else
      begin
        req_v = 1'b1;
        req   = r;
        @(negedge clk);
      end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((busy || pending != 0) && waited < 40)
      begin
        @(negedge clk);
        waited++;
      end
    if (pending != 0)
      begin
        $display("Timeout at %0t: %0d write-backs never arrived", $time, pending);
        timeouts++;
      end
  endtask

  initial
    begin
      clk = 1'b0;
      forever #4 clk = ~clk;
    end

  // Yumi after a random 0 to 5 cycles
  initial
    begin
      iwb_yumi   = 1'b0;
      fwb_yumi   = 1'b0;
      yumi_state = 32'd90476 ^ 32'h9e37_79b9;
      yumi_delay = -1;
      forever
        begin
          @(negedge clk);
          iwb_yumi = 1'b0;
          fwb_yumi = 1'b0;
          if (iwb_v || fwb_v)
            begin
              if (yumi_delay < 0)
                begin
                  yumi_state = xorshift32(yumi_state);
                  yumi_delay = int'(yumi_state % 32'd6);
                end
              if (yumi_delay == 0)
                begin
                  iwb_yumi   = iwb_v;
                  fwb_yumi   = fwb_v;
                  yumi_delay = -1;
                end
              else
                yumi_delay--;
            end
        end
    end

  initial
    begin
      arst_n     = 1'b0;
      req_v      = 1'b0;
      req        = '0;
      stim_state = 32'd90476;
      timeouts   = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      // Fill the scratchpad so every load reads known bytes
      for (int row = 0; row < mem_pkg::MEM_BYTES / 8 && timeouts == 0; row++)
        begin
          req.op      = mem_pkg::e_sd;
          req.rs1     = 64'(row * 8);
          req.imm     = '0;
          req.rs2     = {draw(), 32'(row)};
          req.rd_addr = '0;
          send(req);
        end
      for (int n = 0; n < 600 && timeouts == 0; n++)
        begin
          random_request(req);
          send(req);
        end
      req_v = 1'b0;
      drain();
      repeat (3) @(negedge clk);
      $display("Summary: %0d checks, %0d errors, %0d timeouts", chk_cnt, err_cnt, timeouts);
      if (timeouts != 0 || err_cnt != 0 || pending != 0)
        $display("** FAIL **");
      else
        $display("** PASS **");
      $finish;
    end

endmodule

/* tb/tb_mem_checker.sv */
`timescale 1ns/100ps

module tb_mem_checker
  (input                        clk_i
   , input                      arst_n_i
   , input                      req_v_i
   , input mem_pkg::mem_req_s   req_i
   , input                      busy_i
   // Load misaligned, store misaligned, load fault, store fault
   , input [3:0]                flags_i
   , input                      iwb_v_i
   , input                      fwb_v_i
   , input                      iwb_yumi_i
   , input                      fwb_yumi_i
   , input mem_pkg::wb_pkt_s    wb_i
   , output int                 err_cnt_o
   , output int                 chk_cnt_o
   , output int                 pending_o
   );

  logic [7:0]       model [mem_pkg::MEM_BYTES];
  mem_pkg::wb_pkt_s exp_q [$];
  logic [3:0]       exp_flags = 4'b0000;
  logic             active = 1'b0;
  int               stall = 0;
  int               err_cnt = 0;
  int               chk_cnt = 0;
  int               pending = 0;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;
  assign pending_o = pending;

  function automatic int op_bytes(mem_pkg::mem_op_e op);
    case (op)
      mem_pkg::e_lb, mem_pkg::e_lbu, mem_pkg::e_sb: return 1;
      mem_pkg::e_lh, mem_pkg::e_lhu, mem_pkg::e_sh: return 2;
      mem_pkg::e_ld, mem_pkg::e_sd, mem_pkg::e_fld, mem_pkg::e_fsd: return 8;
      default: return 4;
    endcase
  endfunction

  task automatic compare_bit(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (exp !== act)
      begin
        err_cnt++;
        $display("ERROR %0t: %s expected %b got %b", $time, name, exp, act);
      end
  endtask

  task automatic compare_word(input string name, input mem_pkg::dword_t exp,
                              input mem_pkg::dword_t act);
    chk_cnt++;
    if (exp !== act)
      begin
        err_cnt++;
        $display("ERROR %0t: %s expected %h got %h", $time, name, exp, act);
      end
  endtask

  task automatic flag_problem(input string msg);
    err_cnt++;
    $display("At %0t: %s", $time, msg);
  endtask

  // Reference behavior of one accepted request
  task automatic apply_request(input mem_pkg::mem_req_s r);
    mem_pkg::dword_t    eaddr;
    mem_pkg::dword_t    raw;
    mem_pkg::mem_addr_t base;
    mem_pkg::wb_pkt_s   pkt;
    int                 n;
    logic               store;
    logic               mis;
    logic               oor;
    eaddr = r.rs1 + r.imm;
    n     = op_bytes(r.op);
    store = r.op inside {mem_pkg::e_sb, mem_pkg::e_sh, mem_pkg::e_sw, mem_pkg::e_sd,
                         mem_pkg::e_fsw, mem_pkg::e_fsd};
    mis   = (eaddr % 64'(n)) != 64'd0;
    oor   = !mis && (eaddr >= 64'(mem_pkg::MEM_BYTES));
    exp_flags = {!store && mis, store && mis, !store && oor, store && oor};
    base  = eaddr[mem_pkg::MEM_ADDR_W-1:0];
    raw   = '0;
    if (!mis && !oor)
      begin
        for (int i = 0; i < n; i++)
          if (store)
            model[base + mem_pkg::mem_addr_t'(i)] = r.rs2[i*8 +: 8];
          else
            raw[i*8 +: 8] = model[base + mem_pkg::mem_addr_t'(i)];
        if (!store)
          begin
            if (r.op inside {mem_pkg::e_lb, mem_pkg::e_lh, mem_pkg::e_lw} && raw[n*8-1])
              raw = raw | (~64'd0 << (n*8));
            // NaN-box for single precision
            if (r.op == mem_pkg::e_flw)
              raw[63:32] = 32'hffff_ffff;
            pkt.is_float = r.op inside {mem_pkg::e_flw, mem_pkg::e_fld};
            pkt.rd_addr  = r.rd_addr;
            pkt.rd_data  = raw;
            exp_q.push_back(pkt);
          end
      end
  endtask

  always @(posedge clk_i)
    begin
      active = arst_n_i;
      exp_flags = 4'b0000;
      if (!arst_n_i)
        exp_q.delete();
      else
        begin
          if (((iwb_v_i && iwb_yumi_i) || (fwb_v_i && fwb_yumi_i)) && exp_q.size() != 0)
            void'(exp_q.pop_front());
          if (req_v_i && !busy_i)
            apply_request(req_i);
        end
      pending = exp_q.size();
    end

  always @(negedge clk_i)
    if (active)
      begin
        compare_bit("load_misaligned_o", exp_flags[3], flags_i[3]);
        compare_bit("store_misaligned_o", exp_flags[2], flags_i[2]);
        compare_bit("load_access_fault_o", exp_flags[1], flags_i[1]);
        compare_bit("store_access_fault_o", exp_flags[0], flags_i[0]);
        compare_bit("busy_o", exp_q.size() != 0, busy_i);
        if (iwb_v_i && fwb_v_i)
          flag_problem("iwb_v_o and fwb_v_o are high together");
        else if (iwb_v_i || fwb_v_i)
          begin
            stall = 0;
            if (exp_q.size() == 0)
              flag_problem("a write-back is offered with no load outstanding");
            else
              begin
                compare_bit("iwb_v_o", !exp_q[0].is_float, iwb_v_i);
                compare_bit("fwb_v_o", exp_q[0].is_float, fwb_v_i);
                compare_bit("wb_o.is_float", exp_q[0].is_float, wb_i.is_float);
                compare_word("wb_o.rd_addr", 64'(exp_q[0].rd_addr), 64'(wb_i.rd_addr));
                compare_word("wb_o.rd_data", exp_q[0].rd_data, wb_i.rd_data);
              end
          end
        else if (exp_q.size() != 0)
          begin
            stall++;
            if (stall == 3)
              flag_problem($sformatf("write-back for rd %0d is missing", exp_q[0].rd_addr));
          end
        else
          begin
            stall = 0;
            compare_bit("iwb_v_o", 1'b0, iwb_v_i);
            compare_bit("fwb_v_o", 1'b0, fwb_v_i);
          end
      end

endmodule

/* src/mem_pipe_top.sv */
`timescale 1ns/100ps

module mem_pipe_top
  (input                           clk_i
   , input                         arst_n_i

   , input                         req_v_i
   , input mem_pkg::mem_req_s      req_i
   , output logic                  busy_o

   , output logic                  load_misaligned_o
   , output logic                  store_misaligned_o
   , output logic                  load_access_fault_o
   , output logic                  store_access_fault_o

   , output logic                  iwb_v_o
   , output logic                  fwb_v_o
   , output mem_pkg::wb_pkt_s      wb_o
   , input                         iwb_yumi_i
   , input                         fwb_yumi_i
   );

  logic                stage_v;
  mem_pkg::mem_stage_s stage;
  logic                load_v;
  mem_pkg::wb_pkt_s    load_pkt;
  logic                full;
  logic                stage_load_v;

  mem_agu
   i_mem_agu
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.req_v_i(req_v_i)
     ,.req_i(req_i)

     ,.stage_v_o(stage_v)
     ,.stage_o(stage)

     ,.load_misaligned_o(load_misaligned_o)
     ,.store_misaligned_o(store_misaligned_o)
     ,.load_access_fault_o(load_access_fault_o)
     ,.store_access_fault_o(store_access_fault_o)
     );

  mem_scratchpad
   i_mem_scratchpad
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.stage_v_i(stage_v)
     ,.stage_i(stage)

     ,.load_v_o(load_v)
     ,.load_o(load_pkt)
     );

  mem_late_wb
   i_mem_late_wb
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.load_v_i(load_v)
     ,.load_i(load_pkt)

     ,.iwb_yumi_i(iwb_yumi_i)
     ,.fwb_yumi_i(fwb_yumi_i)

     ,.full_o(full)
     ,.iwb_v_o(iwb_v_o)
     ,.fwb_v_o(fwb_v_o)
     ,.wb_o(wb_o)
     );

  // Stores pass through without holding off the next request
  assign stage_load_v = stage_v & ~mem_pkg::op_is_store(stage.op);

  // Any load in flight or waiting for yumi blocks new requests
  assign busy_o = stage_load_v | load_v | full;

endmodule

/* src/mem_late_wb.sv */
`timescale 1ns/100ps

module mem_late_wb
  (input                           clk_i
   , input                         arst_n_i

   , input                         load_v_i
   , input mem_pkg::wb_pkt_s       load_i

   , input                         iwb_yumi_i
   , input                         fwb_yumi_i

   , output logic                  full_o
   , output logic                  iwb_v_o
   , output logic                  fwb_v_o
   , output mem_pkg::wb_pkt_s      wb_o
   );

  logic yumi;

  // Only a yumi on the port that is offering counts
  assign yumi = (iwb_yumi_i & iwb_v_o) | (fwb_yumi_i & fwb_v_o);

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      full_o <= 1'b0;
    else if (load_v_i)
      full_o <= 1'b1;
    else if (yumi)
      full_o <= 1'b0;

  always_ff @(posedge clk_i)
    if (load_v_i)
      wb_o <= load_i;

  assign iwb_v_o = full_o & ~wb_o.is_float;
  assign fwb_v_o = full_o &  wb_o.is_float;

endmodule

/* src/mem_scratchpad.sv */
`timescale 1ns/100ps

module mem_scratchpad
  (input                           clk_i
   , input                         arst_n_i

   , input                         stage_v_i
   , input mem_pkg::mem_stage_s    stage_i

   , output logic                  load_v_o
   , output mem_pkg::wb_pkt_s      load_o
   );

  // Storage as dword rows with one lane per byte offset
  mem_pkg::dword_t mem_q [mem_pkg::MEM_BYTES/8];

  logic [mem_pkg::MEM_ADDR_W-4:0] row;
  logic [2:0]                     offset;
  logic [7:0]                     size_mask;
  logic [7:0]                     byte_en;
  mem_pkg::dword_t                wdata;
  logic                           wr_en;
  logic                           rd_en;

  mem_pkg::dword_t                rdata_q;
  mem_pkg::mem_op_e               op_q;
  logic [2:0]                     offset_q;
  mem_pkg::reg_addr_t             rd_addr_q;
  mem_pkg::dword_t                shifted;

  assign row    = stage_i.mem_addr[mem_pkg::MEM_ADDR_W-1:3];
  assign offset = stage_i.mem_addr[2:0];
  assign wr_en  = stage_v_i &  mem_pkg::op_is_store(stage_i.op);
  assign rd_en  = stage_v_i & ~mem_pkg::op_is_store(stage_i.op);

  always_comb
    begin
      unique case (stage_i.size)
        2'b00:   size_mask = 8'h01;
        2'b01:   size_mask = 8'h03;
        2'b10:   size_mask = 8'h0f;
        default: size_mask = 8'hff;
      endcase
      byte_en = size_mask << offset;
      wdata   = stage_i.data << {offset, 3'b000};
    end

  always_ff @(posedge clk_i)
    if (wr_en)
      begin
        for (int b = 0; b < 8; b++)
          begin
            if (byte_en[b])
              mem_q[row][b*8 +: 8] <= wdata[b*8 +: 8];
          end
      end

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      load_v_o <= 1'b0;
    else
      load_v_o <= rd_en;

  always_ff @(posedge clk_i)
    if (rd_en)
      begin
        rdata_q   <= mem_q[row];
        op_q      <= stage_i.op;
        offset_q  <= offset;
        rd_addr_q <= stage_i.rd_addr;
      end

  // Move the addressed bytes down to bit 0
  assign shifted = rdata_q >> {offset_q, 3'b000};

  always_comb
    begin
      load_o.rd_addr  = rd_addr_q;
      load_o.is_float = (op_q == mem_pkg::e_flw) || (op_q == mem_pkg::e_fld);
      case (op_q)
        mem_pkg::e_lb:
          load_o.rd_data = {{(mem_pkg::DWORD_W-8){shifted[7]}}, shifted[7:0]};
        mem_pkg::e_lbu:
          load_o.rd_data = {{(mem_pkg::DWORD_W-8){1'b0}}, shifted[7:0]};
        mem_pkg::e_lh:
          load_o.rd_data = {{(mem_pkg::DWORD_W-16){shifted[15]}}, shifted[15:0]};
        mem_pkg::e_lhu:
          load_o.rd_data = {{(mem_pkg::DWORD_W-16){1'b0}}, shifted[15:0]};
        mem_pkg::e_lw:
          load_o.rd_data = {{(mem_pkg::DWORD_W-32){shifted[31]}}, shifted[31:0]};
        mem_pkg::e_lwu:
          load_o.rd_data = {{(mem_pkg::DWORD_W-32){1'b0}}, shifted[31:0]};
        // Single precision is NaN-boxed in the 64-bit register
        mem_pkg::e_flw:
          load_o.rd_data = {{mem_pkg::NANBOX_W{1'b1}}, shifted[31:0]};
        default:
          load_o.rd_data = shifted;
      endcase
    end

endmodule

/* src/mem_agu.sv */
`timescale 1ns/100ps

module mem_agu
  (input                           clk_i
   , input                         arst_n_i

   , input                         req_v_i
   , input mem_pkg::mem_req_s      req_i

   , output logic                  stage_v_o
   , output mem_pkg::mem_stage_s   stage_o

   , output logic                  load_misaligned_o
   , output logic                  store_misaligned_o
   , output logic                  load_access_fault_o
   , output logic                  store_access_fault_o
   );

  mem_pkg::eaddr_t eaddr;
  mem_pkg::size_t  size;
  logic [2:0]      align_mask;
  logic            is_store;
  logic            misaligned;
  logic            out_of_range;

  assign eaddr    = req_i.rs1 + req_i.imm;
  assign is_store = mem_pkg::op_is_store(req_i.op);

  always_comb
    begin
      unique case (req_i.op)
        mem_pkg::e_lb, mem_pkg::e_lbu, mem_pkg::e_sb: size = 2'b00;
        mem_pkg::e_lh, mem_pkg::e_lhu, mem_pkg::e_sh: size = 2'b01;
        mem_pkg::e_lw, mem_pkg::e_lwu, mem_pkg::e_sw
        ,mem_pkg::e_flw, mem_pkg::e_fsw:               size = 2'b10;
        default:                                       size = 2'b11;
      endcase
    end

  // Low address bits that must be zero for the access size
  always_comb
    begin
      unique case (size)
        2'b00:   align_mask = 3'b000;
        2'b01:   align_mask = 3'b001;
        2'b10:   align_mask = 3'b011;
        default: align_mask = 3'b111;
      endcase
    end

  assign misaligned   = |(eaddr[2:0] & align_mask);
  assign out_of_range = |eaddr[mem_pkg::DWORD_W-1:mem_pkg::MEM_ADDR_W];

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      begin
        stage_v_o            <= 1'b0;
        load_misaligned_o    <= 1'b0;
        store_misaligned_o   <= 1'b0;
        load_access_fault_o  <= 1'b0;
        store_access_fault_o <= 1'b0;
      end
    else
      begin
        stage_v_o            <= req_v_i & ~misaligned & ~out_of_range;
        load_misaligned_o    <= req_v_i & ~is_store & misaligned;
        store_misaligned_o   <= req_v_i &  is_store & misaligned;
        // Misalignment takes priority over range
        load_access_fault_o  <= req_v_i & ~is_store & ~misaligned & out_of_range;
        store_access_fault_o <= req_v_i &  is_store & ~misaligned & out_of_range;
      end

  always_ff @(posedge clk_i)
    if (req_v_i)
      begin
        stage_o.mem_addr <= eaddr[mem_pkg::MEM_ADDR_W-1:0];
        stage_o.size     <= size;
        stage_o.op       <= req_i.op;
        stage_o.data     <= req_i.rs2;
        stage_o.rd_addr  <= req_i.rd_addr;
      end

endmodule

/* src/mem_pkg.sv */
package mem_pkg;

  localparam int DWORD_W    = 64;
  localparam int REG_ADDR_W = 5;
  localparam int MEM_BYTES  = 1024;
  localparam int MEM_ADDR_W = 10;
  localparam int NANBOX_W   = 32;

  typedef logic [DWORD_W-1:0]    dword_t;
  typedef logic [DWORD_W-1:0]    eaddr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  // 0, 1, 2, 3 select 1, 2, 4, 8 bytes
  typedef logic [1:0]            size_t;

  typedef enum logic [3:0]
  {
    e_lb   = 4'd0
    ,e_lh  = 4'd1
    ,e_lw  = 4'd2
    ,e_ld  = 4'd3
    ,e_lbu = 4'd4
    ,e_lhu = 4'd5
    ,e_lwu = 4'd6
    ,e_sb  = 4'd7
    ,e_sh  = 4'd8
    ,e_sw  = 4'd9
    ,e_sd  = 4'd10
    ,e_flw = 4'd11
    ,e_fld = 4'd12
    ,e_fsw = 4'd13
    ,e_fsd = 4'd14
  } mem_op_e;

  typedef struct packed
  {
    mem_op_e   op;
    dword_t    rs1;
    dword_t    rs2;
    dword_t    imm;
    reg_addr_t rd_addr;
  } mem_req_s;

  typedef struct packed
  {
    mem_addr_t mem_addr;
    size_t     size;
    mem_op_e   op;
    dword_t    data;
    reg_addr_t rd_addr;
  } mem_stage_s;

  typedef struct packed
  {
    logic      is_float;
    reg_addr_t rd_addr;
    dword_t    rd_data;
  } wb_pkt_s;

  function automatic logic op_is_store(mem_op_e op);
    return op inside {e_sb, e_sh, e_sw, e_sd, e_fsw, e_fsd};
  endfunction

endpackage
